/* project.f */
+incdir+rtl
rtl/calc_pkg.sv
rtl/calc_countdown_if.sv
rtl/key_edge.sv
rtl/err_countdown.sv
rtl/seg_format.sv
rtl/calc_ctrl.sv
rtl/calc_top.sv
sim/calc_properties.sv
sim/calc_tb.sv

/* rtl/calc_countdown_if.sv */
`timescale 1ns/1ps

// Controller to countdown timer
interface calc_countdown_if;
  logic       load;       // One cycle, starts a countdown
  logic [3:0] load_secs;  // Sampled with load
  logic       stop;       // Level, clears and idles the timer
  logic [3:0] secs_left;
  logic       expired;    // One cycle at the tick that finds zero

  modport ctrl (
    output load, load_secs, stop,
    input  secs_left, expired
  );

  modport timer (
    input  load, load_secs, stop,
    output secs_left, expired
  );
endinterface

/* rtl/calc_ctrl.sv */
`timescale 1ns/1ps
`include "calc_defs.svh"

module calc_ctrl (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     start_en,
  input  logic [7:0]               sw_mode_sel,
  input  logic [`CALC_ELEM_W-1:0]  sw_scalar,    // Sign-magnitude
  input  logic                     confirm_pulse,
  input  logic                     esc_pulse,
  input  logic [7:0]               rx_data,
  input  logic                     rx_done,
  input  logic [`CALC_ELEM_W-1:0]  rand_val,
  input  logic [3:0]               cfg_err_countdown,
  input  logic [`CALC_DIM_W-1:0]   mat_a_rows,
  input  logic [`CALC_DIM_W-1:0]   mat_a_cols,
  input  logic [`CALC_DIM_W-1:0]   mat_b_rows,
  input  logic [`CALC_DIM_W-1:0]   mat_b_cols,
  input  logic                     alu_done,
  input  logic                     alu_err,
  output logic                     alu_start,
  output calc_pkg::op_code_t       alu_op_code,
  output logic [`CALC_ID_W-1:0]    alu_id_a,
  output logic [`CALC_ID_W-1:0]    alu_id_b,
  output logic [`CALC_ELEM_W-1:0]  alu_scalar,   // Two's complement
  output logic                     calc_err,
  output logic                     calc_done,
  output calc_pkg::calc_view_t     view,
  calc_countdown_if.ctrl           cd
);

  localparam int EW = `CALC_ELEM_W;

  typedef enum logic [3:0] {
    IDLE, SELECT_OP, GET_ID_A, GET_ID_B, GET_SCALAR, CONFIRM,
    EXEC_ALU, WAIT_ALU, ERR_VALID, ERR_HOLD, DONE_WAIT
  } state_t;

  state_t                 state;
  calc_pkg::op_code_t     op_reg;
  calc_pkg::op_code_t     op_sel;      // Switch decode, live
  logic [`CALC_ID_W-1:0]  id_a;
  logic [`CALC_ID_W-1:0]  id_b;
  logic [EW-1:0]          scalar_latch;
  logic [EW-1:0]          mag_ext;
  logic [EW-1:0]          scalar_shown;
  logic                   rx_id_ok;
  logic                   dims_ok;
  logic                   uses_b;

  // Switch 7 has the highest priority
  always_comb begin
    if (sw_mode_sel[7])      op_sel = calc_pkg::OP_ADD;
    else if (sw_mode_sel[6]) op_sel = calc_pkg::OP_MAT_MUL;
    else if (sw_mode_sel[5]) op_sel = calc_pkg::OP_SCALAR_MUL;
    else if (sw_mode_sel[4]) op_sel = calc_pkg::OP_TRANSPOSE;
    else if (sw_mode_sel[3]) op_sel = calc_pkg::OP_CONV;
    else                     op_sel = calc_pkg::OP_NONE;
  end

  // Dimension check against the slots on alu_id_a/b
  always_comb begin
    case (op_reg)
      calc_pkg::OP_ADD:     dims_ok = (mat_a_rows == mat_b_rows) && (mat_a_cols == mat_b_cols);
      calc_pkg::OP_MAT_MUL: dims_ok = (mat_a_cols == mat_b_rows);
      default:              dims_ok = 1'b1;
    endcase
  end

  assign rx_id_ok = rx_done && (rx_data < 8'(`CALC_SLOTS));
  assign uses_b   = (op_reg == calc_pkg::OP_ADD) || (op_reg == calc_pkg::OP_MAT_MUL);

  assign alu_op_code = op_reg;
  assign alu_id_a    = id_a;
  assign alu_id_b    = id_b;
  assign mag_ext     = {1'b0, scalar_latch[EW-2:0]};
  assign alu_scalar  = scalar_latch[EW-1] ? -mag_ext : mag_ext;  // Sign-magnitude to 2's comp

  assign cd.stop = !((state == ERR_VALID) || (state == ERR_HOLD));  // Timer idles elsewhere

  // ========================================================================
  // Operation FSM
  // ========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= IDLE;
      op_reg       <= calc_pkg::OP_NONE;
      alu_start    <= 1'b0;
      calc_err     <= 1'b0;
      calc_done    <= 1'b0;
      cd.load      <= 1'b0;
      cd.load_secs <= 4'd0;
    end else begin
      alu_start <= 1'b0;  // Pulses
      calc_done <= 1'b0;
      cd.load   <= 1'b0;
      case (state)
        IDLE: if (start_en) state <= SELECT_OP;
        SELECT_OP: begin
          if (esc_pulse) begin
            calc_done <= 1'b1;  // Leave calculator mode
            state     <= IDLE;
          end else if (confirm_pulse && op_sel != calc_pkg::OP_NONE) begin
            op_reg <= op_sel;
            state  <= GET_ID_A;
          end
        end
        GET_ID_A: begin
          if (esc_pulse) state <= SELECT_OP;
          else if (rx_id_ok) begin
            if (uses_b)                                 state <= GET_ID_B;
            else if (op_reg == calc_pkg::OP_SCALAR_MUL) state <= GET_SCALAR;
            else                                        state <= CONFIRM;
          end
        end
        GET_ID_B: begin
          if (esc_pulse)     state <= SELECT_OP;
          else if (rx_id_ok) state <= CONFIRM;
        end
        GET_SCALAR: begin
          if (esc_pulse)          state <= SELECT_OP;
          else if (confirm_pulse) state <= CONFIRM;
        end
        CONFIRM: begin
          if (esc_pulse) state <= SELECT_OP;
          else if (confirm_pulse) begin
            if (dims_ok) begin
              state <= EXEC_ALU;
            end else begin
              calc_err     <= 1'b1;
              cd.load      <= 1'b1;
              cd.load_secs <= cfg_err_countdown;
              state        <= ERR_VALID;
            end
          end
        end
        EXEC_ALU: begin
          alu_start <= 1'b1;
          state     <= WAIT_ALU;
        end
        WAIT_ALU: begin
          if (alu_err) begin
            calc_err     <= 1'b1;
            cd.load      <= 1'b1;
            cd.load_secs <= 4'(`CALC_HOLD_SECS);
            state        <= ERR_HOLD;
          end else if (alu_done) begin
            state <= DONE_WAIT;
          end
        end
        ERR_VALID: begin  // B may be re-entered meanwhile
          if (confirm_pulse) begin
            if (dims_ok) begin
              calc_err <= 1'b0;
              state    <= EXEC_ALU;
            end else begin
              cd.load      <= 1'b1;  // Restart countdown
              cd.load_secs <= cfg_err_countdown;
            end
          end else if (esc_pulse || cd.expired) begin
            calc_err <= 1'b0;
            state    <= SELECT_OP;
          end
        end
        ERR_HOLD: begin
          if (esc_pulse || cd.expired) begin
            calc_err <= 1'b0;
            state    <= SELECT_OP;
          end
        end
        DONE_WAIT: if (esc_pulse || confirm_pulse) state <= SELECT_OP;
        default: state <= IDLE;
      endcase
    end
  end

  // Operand IDs and scalar
  always_ff @(posedge clk) begin
    if (rx_id_ok && state == GET_ID_A) begin
      id_a <= rx_data[`CALC_ID_W-1:0];
      if (op_reg == calc_pkg::OP_CONV) id_b <= rx_data[`CALC_ID_W-1:0];  // Kernel in B
    end else if (rx_id_ok && (state == GET_ID_B || state == ERR_VALID)) begin
      id_b <= rx_data[`CALC_ID_W-1:0];
    end
    if (confirm_pulse && state == GET_SCALAR) begin
      scalar_latch <= (sw_scalar == '0) ? rand_val % EW'(10) : sw_scalar;  // Zero picks 0..9
    end
  end

  // ========================================================================
  // Display view
  // ========================================================================
  assign scalar_shown = (state == GET_SCALAR) ? sw_scalar : scalar_latch;

  always_comb begin
    view.op     = (state == SELECT_OP) ? op_sel : op_reg;  // Preview while choosing
    view.id_a   = id_a;
    view.id_b   = id_b;
    view.show_a = (state != GET_ID_A);
    view.show_b = uses_b && (state != GET_ID_A) && (state != GET_ID_B);
    view.sign   = scalar_shown[EW-1];
    view.mag    = scalar_shown[EW-2:0];
    view.secs   = cd.secs_left;
    case (state)
      IDLE:      view.phase = calc_pkg::VIEW_BLANK;
      SELECT_OP: view.phase = calc_pkg::VIEW_OP;
      ERR_VALID: view.phase = calc_pkg::VIEW_ERR_VALID;
      DONE_WAIT: view.phase = calc_pkg::VIEW_DONE;
      default: begin
        if (op_reg == calc_pkg::OP_SCALAR_MUL && state != GET_ID_A)
          view.phase = calc_pkg::VIEW_SCALAR;
        else
          view.phase = calc_pkg::VIEW_IDS;
      end
    endcase
  end

endmodule

/* rtl/calc_defs.svh */
`ifndef CALC_DEFS_SVH
`define CALC_DEFS_SVH

// ==========================================================================
// Widths
// ==========================================================================
`define CALC_ID_W 5          // Matrix slot ID
`define CALC_SLOTS 32        // Slot count, rx bytes below this are IDs
`define CALC_DIM_W 3         // Row or column count
`define CALC_ELEM_W 8        // ALU scalar

// ==========================================================================
// Timing
// ==========================================================================
// Cycles per countdown second, 100000000 at 100 MHz on the board
`define CALC_TICK_CYCLES 16
`define CALC_HOLD_SECS 5     // ALU error hold length

`endif

/* rtl/calc_pkg.sv */
`include "calc_defs.svh"

package calc_pkg;

  // Operation latched from the mode switches
  typedef enum logic [2:0] {
    OP_NONE,
    OP_ADD,
    OP_MAT_MUL,
    OP_SCALAR_MUL,
    OP_TRANSPOSE,
    OP_CONV
  } op_code_t;

  // Digit code, 0..15 are plain hex digits
  typedef logic [4:0] seg_char_t;

  localparam seg_char_t CH_A     = 5'd16;
  localparam seg_char_t CH_B     = 5'd17;  // Lower case b
  localparam seg_char_t CH_C     = 5'd18;
  localparam seg_char_t CH_E     = 5'd19;
  localparam seg_char_t CH_R     = 5'd20;  // Lower case r
  localparam seg_char_t CH_Y     = 5'd21;
  localparam seg_char_t CH_L     = 5'd22;
  localparam seg_char_t CH_T     = 5'd23;  // Lower case t
  localparam seg_char_t CH_J     = 5'd24;
  localparam seg_char_t CH_DASH  = 5'd25;
  localparam seg_char_t CH_BLANK = 5'd26;

  // What the display is showing
  typedef enum logic [2:0] {
    VIEW_BLANK,
    VIEW_OP,
    VIEW_IDS,
    VIEW_SCALAR,
    VIEW_ERR_VALID,
    VIEW_DONE
  } view_phase_t;

  // Controller state as seen by the display formatter
  typedef struct packed {
    view_phase_t              phase;
    op_code_t                 op;
    logic [`CALC_ID_W-1:0]    id_a;
    logic [`CALC_ID_W-1:0]    id_b;
    logic                     show_a;  // A digits entered
    logic                     show_b;  // B in use and entered
    logic                     sign;
    logic [`CALC_ELEM_W-2:0]  mag;
    logic [3:0]               secs;
  } calc_view_t;

endpackage

/* rtl/calc_top.sv */
`timescale 1ns/1ps
`include "calc_defs.svh"

module calc_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       start_en,
  input  logic [7:0]                 sw_mode_sel,
  input  logic [`CALC_ELEM_W-1:0]    sw_scalar,
  input  logic                       btn_confirm,
  input  logic                       btn_esc,
  input  logic [7:0]                 rx_data,
  input  logic                       rx_done,
  input  logic [`CALC_ELEM_W-1:0]    rand_val,
  input  logic [3:0]                 cfg_err_countdown,
  input  logic [`CALC_DIM_W-1:0]     mat_a_rows,
  input  logic [`CALC_DIM_W-1:0]     mat_a_cols,
  input  logic [`CALC_DIM_W-1:0]     mat_b_rows,
  input  logic [`CALC_DIM_W-1:0]     mat_b_cols,
  input  logic                       alu_done,
  input  logic                       alu_err,
  input  logic [31:0]                alu_cycle_cnt,
  output logic                       alu_start,
  output calc_pkg::op_code_t         alu_op_code,
  output logic [`CALC_ID_W-1:0]      alu_id_a,
  output logic [`CALC_ID_W-1:0]      alu_id_b,
  output logic [`CALC_ELEM_W-1:0]    alu_scalar,
  output logic                       calc_err,
  output logic                       calc_done,
  output calc_pkg::seg_char_t [7:0]  seg_data
);

  logic                 confirm_pulse;
  logic                 esc_pulse;
  calc_pkg::calc_view_t view;

  calc_countdown_if cd_if ();

  // Button edges
  key_edge u_keys (
    .clk, .rst_n, .btn_confirm, .btn_esc, .confirm_pulse, .esc_pulse
  );

  calc_ctrl u_ctrl (
    .clk, .rst_n, .start_en, .sw_mode_sel, .sw_scalar,
    .confirm_pulse, .esc_pulse, .rx_data, .rx_done, .rand_val, .cfg_err_countdown,
    .mat_a_rows, .mat_a_cols, .mat_b_rows, .mat_b_cols,
    .alu_done, .alu_err, .alu_start, .alu_op_code, .alu_id_a, .alu_id_b,
    .alu_scalar, .calc_err, .calc_done, .view,
    .cd (cd_if.ctrl)
  );

  // Seconds for both error countdowns
  err_countdown u_timer (
    .clk, .rst_n,
    .cd (cd_if.timer)
  );

  seg_format u_seg (
    .clk, .rst_n, .view, .alu_cycle_cnt, .seg_data
  );

endmodule

/* rtl/err_countdown.sv */
`timescale 1ns/1ps
`include "calc_defs.svh"

module err_countdown (
  input logic            clk,
  input logic            rst_n,
  calc_countdown_if.timer cd
);

  localparam int TICKS = `CALC_TICK_CYCLES;
  localparam int PW    = (TICKS > 1) ? $clog2(TICKS) : 1;

  logic [PW-1:0] presc;   // Cycles within the current second
  logic [3:0]    secs;
  logic          active;
  logic          tick;

  assign tick         = active && (presc == PW'(TICKS - 1));
  assign cd.secs_left = secs;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      presc      <= '0;
      secs       <= 4'd0;
      active     <= 1'b0;
      cd.expired <= 1'b0;
    end else begin
      cd.expired <= 1'b0;
      if (cd.stop) begin       // Stop wins over load
        presc  <= '0;
        secs   <= 4'd0;
        active <= 1'b0;
      end else if (cd.load) begin
        presc  <= '0;
        secs   <= cd.load_secs;
        active <= 1'b1;
      end else if (tick) begin
        presc <= '0;
        if (secs == 4'd0) begin
          cd.expired <= 1'b1;  // Last second used up
          active     <= 1'b0;
        end else begin
          secs <= secs - 4'd1;
        end
      end else if (active) begin
        presc <= presc + PW'(1);
      end
    end
  end

endmodule

/* rtl/key_edge.sv */
`timescale 1ns/1ps

module key_edge (
  input  logic clk,
  input  logic rst_n,
  input  logic btn_confirm,
  input  logic btn_esc,
  output logic confirm_pulse,
  output logic esc_pulse
);

  logic [1:0] btn_prev;  // Last level, {confirm, esc}

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      btn_prev <= 2'b00;
    end else begin
      btn_prev <= {btn_confirm, btn_esc};
    end
  end

  // High in the first cycle a button is seen up
  assign {confirm_pulse, esc_pulse} = {btn_confirm, btn_esc} & ~btn_prev;

endmodule

/* rtl/seg_format.sv */
`timescale 1ns/1ps

module seg_format (
  input  logic                       clk,
  input  logic                       rst_n,
  input  calc_pkg::calc_view_t       view,
  input  logic [31:0]                alu_cycle_cnt,
  output calc_pkg::seg_char_t [7:0]  seg_data
);

  calc_pkg::seg_char_t [7:0] digits;

  // Decimal tens, hundreds dropped
  function automatic calc_pkg::seg_char_t dec_tens(input logic [6:0] v);
    return calc_pkg::seg_char_t'((v / 7'd10) % 7'd10);
  endfunction

  function automatic calc_pkg::seg_char_t dec_ones(input logic [6:0] v);
    return calc_pkg::seg_char_t'(v % 7'd10);
  endfunction

  function automatic calc_pkg::seg_char_t hex_digit(input logic [3:0] nib);
    return calc_pkg::seg_char_t'({1'b0, nib});
  endfunction

  function automatic calc_pkg::seg_char_t op_char(input calc_pkg::op_code_t op);
    case (op)
      calc_pkg::OP_ADD:        return calc_pkg::CH_A;
      calc_pkg::OP_MAT_MUL:    return calc_pkg::CH_B;
      calc_pkg::OP_SCALAR_MUL: return calc_pkg::CH_C;
      calc_pkg::OP_TRANSPOSE:  return calc_pkg::CH_T;
      calc_pkg::OP_CONV:       return calc_pkg::CH_J;
      default:                 return calc_pkg::CH_BLANK;
    endcase
  endfunction

  // ========================================================================
  // Layout per phase, digit 7 leftmost
  // ========================================================================
  always_comb begin
    digits = {8{calc_pkg::CH_BLANK}};
    case (view.phase)
      calc_pkg::VIEW_OP: begin
        digits[7] = op_char(view.op);
      end
      calc_pkg::VIEW_IDS, calc_pkg::VIEW_SCALAR: begin
        digits[7] = calc_pkg::CH_A;
        if (view.show_a) begin
          digits[5] = dec_tens(7'(view.id_a));
          digits[4] = dec_ones(7'(view.id_a));
        end
        digits[3] = calc_pkg::CH_B;
        if (view.phase == calc_pkg::VIEW_SCALAR) begin
          digits[2] = view.sign ? calc_pkg::CH_DASH : calc_pkg::CH_BLANK;
          digits[1] = dec_tens(view.mag);
          digits[0] = dec_ones(view.mag);
        end else if (view.show_b) begin
          digits[1] = dec_tens(7'(view.id_b));
          digits[0] = dec_ones(7'(view.id_b));
        end
      end
      calc_pkg::VIEW_ERR_VALID: begin  // b Err, then seconds left
        digits[7] = calc_pkg::CH_B;
        digits[5] = calc_pkg::CH_E;
        digits[4] = calc_pkg::CH_R;
        digits[3] = calc_pkg::CH_R;
        digits[1] = dec_tens(7'(view.secs));
        digits[0] = dec_ones(7'(view.secs));
      end
      calc_pkg::VIEW_DONE: begin  // CYCL and low 16 bits of the cycle count
        digits[7] = calc_pkg::CH_C;
        digits[6] = calc_pkg::CH_Y;
        digits[5] = calc_pkg::CH_C;
        digits[4] = calc_pkg::CH_L;
        digits[3] = hex_digit(alu_cycle_cnt[15:12]);
        digits[2] = hex_digit(alu_cycle_cnt[11:8]);
        digits[1] = hex_digit(alu_cycle_cnt[7:4]);
        digits[0] = hex_digit(alu_cycle_cnt[3:0]);
      end
      default: ;  // Blank
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seg_data <= {8{calc_pkg::CH_BLANK}};
    end else begin
      seg_data <= digits;
    end
  end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the calculator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module calc_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vcalc_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "TEST PASS"; then
  exit 0
fi
exit 1

/* sim/calc_properties.sv */
`timescale 1ns/1ps

module calc_properties (
  input logic clk,
  input logic rst_n,
  input logic alu_start,
  input logic calc_done,
  input logic calc_err
);

  // ========================================================================
  // Controller strobes
  // ========================================================================
  a_start_pulse: assert property (
    @(posedge clk) disable iff (!rst_n) alu_start |=> !alu_start
  ) else $error("alu_start high for more than one cycle");

  a_done_pulse: assert property (
    @(posedge clk) disable iff (!rst_n) calc_done |=> !calc_done
  ) else $error("calc_done high for more than one cycle");

  // No launch while an error is flagged
  a_start_no_err: assert property (
    @(posedge clk) disable iff (!rst_n) alu_start |-> !calc_err
  ) else $error("alu_start raised while calc_err is high");

endmodule

bind calc_ctrl calc_properties u_props (
  .clk, .rst_n, .alu_start, .calc_done, .calc_err
);

/* sim/calc_tb.sv */
`timescale 1ns/1ps
`include "calc_defs.svh"

module calc_tb;

  localparam int NROWS    = 9;
  localparam int TICK     = `CALC_TICK_CYCLES;
  localparam int CFG_SECS = 9;

  typedef calc_pkg::seg_char_t [7:0] digits_t;

  // Stimulus, then expected values
  typedef struct {
    logic [7:0]          mode;
    calc_pkg::op_code_t  op;
    logic [4:0]          id_a;
    logic [4:0]          id_b;
    logic [7:0]          sw;
    logic [2:0]          a_rows;
    logic [2:0]          a_cols;
    logic [2:0]          b_rows;
    logic [2:0]          b_cols;
    logic [7:0]          scalar;    // alu_scalar, unused when sw is zero
    bit                  dims_ok;
    bit                  alu_fail;  // ALU model answers with alu_err
    bit                  err_esc;   // Leave ERR_VALID by escape
  } row_t;

  logic                      clk = 1'b0;
  logic                      rst_n;
  logic                      start_en;
  logic [7:0]                sw_mode_sel;
  logic [`CALC_ELEM_W-1:0]   sw_scalar;
  logic                      btn_confirm;
  logic                      btn_esc;
  logic [7:0]                rx_data;
  logic                      rx_done;
  logic [`CALC_ELEM_W-1:0]   rand_val;
  logic [3:0]                cfg_err_countdown;
  logic [`CALC_DIM_W-1:0]    mat_a_rows;
  logic [`CALC_DIM_W-1:0]    mat_a_cols;
  logic [`CALC_DIM_W-1:0]    mat_b_rows;
  logic [`CALC_DIM_W-1:0]    mat_b_cols;
  logic                      alu_done;
  logic                      alu_err;
  logic [31:0]               alu_cycle_cnt;
  logic                      alu_start;
  calc_pkg::op_code_t        alu_op_code;
  logic [`CALC_ID_W-1:0]     alu_id_a;
  logic [`CALC_ID_W-1:0]     alu_id_b;
  logic [`CALC_ELEM_W-1:0]   alu_scalar;
  logic                      calc_err;
  logic                      calc_done;
  digits_t                   seg_data;

  logic [`CALC_DIM_W-1:0]    slot_rows [`CALC_SLOTS];  // Matrix store model
  logic [`CALC_DIM_W-1:0]    slot_cols [`CALC_SLOTS];
  row_t                      rows [NROWS];
  logic [31:0]               lfsr_state;
  int                        alu_delay;
  bit                        alu_fail;
  int                        errors;
  int                        tests_failed;

  calc_top uut (.*);

  always #10 clk = ~clk;  // 20 ns

  // Dimensions follow the slots on the ALU ID outputs
  assign mat_a_rows = slot_rows[alu_id_a];
  assign mat_a_cols = slot_cols[alu_id_a];
  assign mat_b_rows = slot_rows[alu_id_b];
  assign mat_b_cols = slot_cols[alu_id_b];

  // ========================================================================
  // Helpers
  // ========================================================================
  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] lfsr_take(input int nbits);
    logic [31:0] v;
    logic        fb;
    int          k;
    v = '0;
    for (k = 0; k < nbits; k++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic digits_t op_view(input calc_pkg::op_code_t op);
    digits_t d;
    d = {8{calc_pkg::CH_BLANK}};
    case (op)
      calc_pkg::OP_ADD:        d[7] = calc_pkg::CH_A;
      calc_pkg::OP_MAT_MUL:    d[7] = calc_pkg::CH_B;
      calc_pkg::OP_SCALAR_MUL: d[7] = calc_pkg::CH_C;
      calc_pkg::OP_TRANSPOSE:  d[7] = calc_pkg::CH_T;
      calc_pkg::OP_CONV:       d[7] = calc_pkg::CH_J;
      default: ;
    endcase
    return d;
  endfunction

  function automatic digits_t ids_view(input int a, input int b, input bit use_b);
    digits_t d;
    d = {8{calc_pkg::CH_BLANK}};
    d[7] = calc_pkg::CH_A;
    d[5] = calc_pkg::seg_char_t'(a / 10);
    d[4] = calc_pkg::seg_char_t'(a % 10);
    d[3] = calc_pkg::CH_B;
    if (use_b) begin
      d[1] = calc_pkg::seg_char_t'(b / 10);
      d[0] = calc_pkg::seg_char_t'(b % 10);
    end
    return d;
  endfunction

  function automatic digits_t scalar_view(input int a, input logic [7:0] latch);
    digits_t d;
    d = ids_view(a, 0, 1'b0);
    d[2] = latch[7] ? calc_pkg::CH_DASH : calc_pkg::CH_BLANK;
    d[1] = calc_pkg::seg_char_t'(int'(latch[6:0]) / 10);
    d[0] = calc_pkg::seg_char_t'(int'(latch[6:0]) % 10);
    return d;
  endfunction

  function automatic digits_t err_view(input int secs);
    digits_t d;
    d = {8{calc_pkg::CH_BLANK}};
    d[7] = calc_pkg::CH_B;
    d[5] = calc_pkg::CH_E;
    d[4] = calc_pkg::CH_R;
    d[3] = calc_pkg::CH_R;
    d[1] = calc_pkg::seg_char_t'(secs / 10);
    d[0] = calc_pkg::seg_char_t'(secs % 10);
    return d;
  endfunction

  function automatic digits_t done_view(input logic [31:0] cnt);
    digits_t d;
    d[7] = calc_pkg::CH_C;
    d[6] = calc_pkg::CH_Y;
    d[5] = calc_pkg::CH_C;
    d[4] = calc_pkg::CH_L;
    d[3] = {1'b0, cnt[15:12]};  // Hex of the low half
    d[2] = {1'b0, cnt[11:8]};
    d[1] = {1'b0, cnt[7:4]};
    d[0] = {1'b0, cnt[3:0]};
    return d;
  endfunction

  task automatic report_mismatch(input string msg);
    $display("** Error @ %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic close_test(input string name, input int err0);
    if (errors > err0) begin
      tests_failed++;
      $display("%s: failed", name);
    end else begin
      $display("%s: ok", name);
    end
  endtask

  // One press, held for one cycle
  task automatic press(input bit esc);
    @(posedge clk);
    if (esc) btn_esc <= 1'b1;
    else btn_confirm <= 1'b1;
    @(posedge clk);
    btn_esc     <= 1'b0;
    btn_confirm <= 1'b0;
    @(posedge clk);
  endtask

  task automatic send_id(input logic [7:0] id);
    @(posedge clk);
    rx_data <= id;
    rx_done <= 1'b1;
    @(posedge clk);
    rx_done <= 1'b0;
    @(posedge clk);
  endtask

  task automatic wait_seg(input digits_t exp, input int limit, input string what);
    int n;
    n = 0;
    @(negedge clk);
    while (seg_data !== exp && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (seg_data !== exp)
      report_mismatch($sformatf("%s display %h, expected %h", what, seg_data, exp));
  endtask

  // Cycles waited come back in waited
  task automatic wait_err(input logic level, input int limit, output int waited);
    int n;
    n = 0;
    @(negedge clk);
    while (calc_err !== level && n < limit) begin
      @(negedge clk);
      n++;
    end
    waited = n;
    if (calc_err !== level) begin
      $display("Timeout: calc_err did not become %0b within %0d cycles", level, limit);
      errors++;
    end
  endtask

  // Cycles from the edge that drives confirm to alu_start, -1 if none
  task automatic confirm_and_time(output int lat);
    int n;
    n = 0;
    lat = -1;
    @(posedge clk);
    btn_confirm <= 1'b1;
    while (lat < 0 && n < 6) begin
      @(posedge clk);
      btn_confirm <= 1'b0;
      n++;
      @(negedge clk);
      if (alu_start === 1'b1) lat = n;
    end
    if (lat > 0) begin
      if (calc_err !== 1'b0) report_mismatch("alu_start with calc_err high");
      @(negedge clk);
      if (alu_start !== 1'b0) report_mismatch("alu_start longer than one cycle");
    end
  endtask

  // ========================================================================
  // One table row, from SELECT_OP back to SELECT_OP
  // ========================================================================
  task automatic run_row(input int i);
    row_t        r;
    int          lat;
    int          held;
    int          err0;
    bit          use_b;
    bit          launched;
    logic [7:0]  rv;
    logic [7:0]  latch;
    logic [7:0]  exp_scalar;
    logic [4:0]  exp_b;
    logic [31:0] cc;
    r = rows[i];
    err0 = errors;
    use_b = (r.op == calc_pkg::OP_ADD) || (r.op == calc_pkg::OP_MAT_MUL);
    rv = 8'(lfsr_take(8));
    cc = lfsr_take(32);
    alu_delay = 1 + int'(lfsr_take(3));
    alu_fail = r.alu_fail;
    latch = (r.sw == 8'd0) ? 8'(rv % 8'd10) : r.sw;
    exp_scalar = (r.sw == 8'd0) ? latch : r.scalar;
    exp_b = r.dims_ok ? r.id_b : r.id_a;  // Recovery re-enters A as B
    slot_rows[r.id_b] = r.b_rows;
    slot_cols[r.id_b] = r.b_cols;
    slot_rows[r.id_a] = r.a_rows;
    slot_cols[r.id_a] = r.a_cols;
    @(posedge clk);
    sw_mode_sel   <= r.mode;
    sw_scalar     <= r.sw;
    rand_val      <= rv;
    alu_cycle_cnt <= cc;
    wait_seg(op_view(r.op), 4, "op preview");
    press(1'b0);
    send_id(r.id_a);
    if (use_b) send_id(r.id_b);
    if (r.op == calc_pkg::OP_SCALAR_MUL) begin
      press(1'b0);
      wait_seg(scalar_view(r.id_a, latch), 4, "scalar");
    end else begin
      wait_seg(ids_view(r.id_a, r.id_b, use_b), 4, "operands");
    end
    confirm_and_time(lat);
    launched = 1'b1;
    if (!r.dims_ok) begin
      if (lat >= 0) report_mismatch("ALU started with invalid dimensions");
      if (calc_err !== 1'b1) report_mismatch("calc_err low after invalid dimensions");
      wait_seg(err_view(CFG_SECS), 4, "dimension error");
      if (r.err_esc) begin
        press(1'b1);
        wait_err(1'b0, 4, held);
        wait_seg(op_view(r.op), 4, "op after escape");
        launched = 1'b0;
      end else begin
        send_id(r.id_a);
        confirm_and_time(lat);
      end
    end
    if (launched) begin
      if (lat < 0) $display("alu_start never rose after confirm, row %0d", i);
      if (lat < 0) errors++;
      else if (lat != 2) report_mismatch($sformatf("alu_start after %0d cycles, expected 2", lat));
      if (alu_op_code !== r.op || alu_id_a !== r.id_a)
        report_mismatch($sformatf("op %0d id_a %0d, expected op %0d id_a %0d",
                                  alu_op_code, alu_id_a, r.op, r.id_a));
      if ((use_b || r.op == calc_pkg::OP_CONV) && alu_id_b !== exp_b)
        report_mismatch($sformatf("id_b %0d, expected %0d", alu_id_b, exp_b));
      if (r.op == calc_pkg::OP_SCALAR_MUL && alu_scalar !== exp_scalar)
        report_mismatch($sformatf("scalar %h, expected %h", alu_scalar, exp_scalar));
      if (r.alu_fail) begin
        wait_err(1'b1, 16, held);
        wait_err(1'b0, (`CALC_HOLD_SECS + 2) * TICK, held);
        if (held < `CALC_HOLD_SECS * TICK)  // Hold shorter than its seconds
          report_mismatch($sformatf("ALU error hold ended after %0d cycles", held));
        wait_seg(op_view(r.op), 4, "op after ALU error");
      end else begin
        wait_seg(done_view(cc), 16, "cycle count");
        press(1'b0);
        wait_seg(op_view(r.op), 4, "op after done");
      end
    end
    close_test($sformatf("Test %0d %s", i, r.op.name()), err0);
  endtask

  // ========================================================================
  // Main sequence
  // ========================================================================
  initial begin : main
    int k;
    int err0;
    int n_done;
    rst_n             <= 1'b0;
    start_en          <= 1'b0;
    sw_mode_sel       <= 8'h00;
    sw_scalar         <= '0;
    btn_confirm       <= 1'b0;
    btn_esc           <= 1'b0;
    rx_data           <= 8'h00;
    rx_done           <= 1'b0;
    rand_val          <= '0;
    cfg_err_countdown <= 4'(CFG_SECS);
    alu_cycle_cnt     <= 32'h0;
    errors = 0;
    tests_failed = 0;
    lfsr_state = 32'd75484;
    for (k = 0; k < `CALC_SLOTS; k++) begin
      slot_rows[k] = 3'(k + (k >> 3));
      slot_cols[k] = 3'(k ^ (k >> 2));
    end
    //        mode   op                      a   b   sw     ar ac br bc scal ok fl esc
    rows[0] = '{8'h80, calc_pkg::OP_ADD,        3,  7, 8'h00, 2, 3, 2, 3, 8'h00, 1, 0, 0};
    rows[1] = '{8'h40, calc_pkg::OP_MAT_MUL,   12, 25, 8'h00, 2, 4, 4, 3, 8'h00, 1, 0, 0};
    rows[2] = '{8'h08, calc_pkg::OP_CONV,       9,  9, 8'h00, 3, 3, 3, 3, 8'h00, 1, 0, 0};
    rows[3] = '{8'h18, calc_pkg::OP_TRANSPOSE, 30, 30, 8'h00, 2, 5, 2, 5, 8'h00, 1, 0, 0};
    rows[4] = '{8'h2C, calc_pkg::OP_SCALAR_MUL, 5,  5, 8'h85, 1, 1, 1, 1, 8'hFB, 1, 0, 0};
    rows[5] = '{8'h20, calc_pkg::OP_SCALAR_MUL,17, 17, 8'h00, 1, 1, 1, 1, 8'h00, 1, 0, 0};
    rows[6] = '{8'hC0, calc_pkg::OP_ADD,        4, 11, 8'h00, 3, 2, 2, 3, 8'h00, 0, 0, 0};
    rows[7] = '{8'h80, calc_pkg::OP_ADD,        6,  8, 8'h00, 1, 2, 2, 1, 8'h00, 0, 0, 1};
    rows[8] = '{8'h40, calc_pkg::OP_MAT_MUL,   20, 21, 8'h00, 3, 5, 5, 2, 8'h00, 1, 1, 0};

    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    err0 = errors;
    if (alu_start !== 1'b0 || calc_done !== 1'b0 || calc_err !== 1'b0)
      report_mismatch("controller strobes not low after reset");
    if (seg_data !== {8{calc_pkg::CH_BLANK}})
      report_mismatch($sformatf("display %h after reset, expected blank", seg_data));
    close_test("Test reset", err0);

    @(posedge clk);
    start_en <= 1'b1;   // IDLE to SELECT_OP
    @(posedge clk);
    start_en <= 1'b0;
    for (k = 0; k < NROWS; k++) run_row(k);

    // Escape in SELECT_OP, one calc_done pulse
    err0 = errors;
    n_done = 0;
    @(posedge clk);
    btn_esc <= 1'b1;
    repeat (6) begin
      @(posedge clk);
      btn_esc <= 1'b0;
      @(negedge clk);
      if (calc_done === 1'b1) n_done++;
    end
    if (n_done != 1) report_mismatch($sformatf("%0d calc_done cycles, expected 1", n_done));
    wait_seg({8{calc_pkg::CH_BLANK}}, 4, "idle");
    close_test("Test exit", err0);

    $display("Tests %0d, failed %0d, errors %0d", NROWS + 2, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Behavioral ALU, answers each start after alu_delay cycles
  initial begin : alu_model
    alu_done <= 1'b0;
    alu_err  <= 1'b0;
    forever begin
      @(posedge clk);
      if (alu_start === 1'b1) begin
        repeat (alu_delay) @(posedge clk);
        if (alu_fail) alu_err <= 1'b1;
        else alu_done <= 1'b1;
        @(posedge clk);
        alu_err  <= 1'b0;
        alu_done <= 1'b0;
      end
    end
  end

endmodule
